// ==== common/cpu_config.svh ====
// reset pc, pc step, and mips32 opcode and funct codes
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// program counter
`define CPU_RESET_PC 32'h0000_0000
`define CPU_PC_STEP  32'd4

// primary opcodes, inst[31:26]
`define OP_SPECIAL 6'b000000  // r-type, decoded by funct
`define OP_ADDIU   6'b001001
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111

// special funct codes, inst[5:0]
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_MFHI 6'b010000
`define FN_MTHI 6'b010001
`define FN_MFLO 6'b010010
`define FN_MTLO 6'b010011
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111

`endif

// ==== common/cpu_pkg.sv ====
// word and address types, alu operation enum and pipeline structs
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] inst_t;      // instruction word
    typedef logic [31:0] addr_t;      // instruction address
    typedef logic [31:0] word_t;      // gpr, hi, lo and alu data
    typedef logic [4:0]  reg_addr_t;  // gpr number

    // execute operations
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_MFHI,
        ALU_MFLO,
        ALU_MTHI,
        ALU_MTLO
    } alu_op_t;

    // one gpr write, also used as a forward
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } reg_wr_t;

    // one hi/lo update
    typedef struct packed {
        logic  hi_we;
        logic  lo_we;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

    // decoded instruction
    typedef struct packed {
        alu_op_t   op;
        word_t     opnd1;
        word_t     opnd2;
        logic [4:0] shamt;
        logic      we;
        reg_addr_t waddr;
    } id_ex_t;

    // execute result
    typedef struct packed {
        reg_wr_t  rd;
        hilo_wr_t hl;
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
// program counter, rom enable and if/id register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module fetch_stage (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire cpu_pkg::inst_t rom_data_i,
    output logic                rom_ce_o,
    output cpu_pkg::addr_t      rom_addr_o,
    output cpu_pkg::addr_t      if_pc_o,
    output cpu_pkg::inst_t      if_inst_o
);

    cpu_pkg::addr_t pc_q;

    // rom enable comes up one edge after reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rom_ce_o <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `CPU_RESET_PC;
        end else if (rom_ce_o) begin
            pc_q <= pc_q + `CPU_PC_STEP;  // step only while fetching
        end
    end

    assign rom_addr_o = pc_q;

    // if/id register, zero word is a no-op
    always_ff @(posedge clk) begin
        if (rst_i || !rom_ce_o) begin
            if_pc_o   <= `CPU_RESET_PC;
            if_inst_o <= '0;
        end else begin
            if_pc_o   <= pc_q;
            if_inst_o <= rom_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
// instruction decoder, operand selection and id/ex register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module decode_stage (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire cpu_pkg::inst_t if_inst_i,
    input  wire cpu_pkg::word_t rdata1_i,
    input  wire cpu_pkg::word_t rdata2_i,
    output logic                re1_o,
    output cpu_pkg::reg_addr_t  raddr1_o,
    output logic                re2_o,
    output cpu_pkg::reg_addr_t  raddr2_o,
    output cpu_pkg::id_ex_t     id_ex_o
);

    // instruction fields
    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    logic [4:0]         shamt;
    logic [15:0]        imm;
    logic               is_itype;

    cpu_pkg::word_t     imm_zext;
    cpu_pkg::word_t     imm_sext;
    cpu_pkg::word_t     imm_lui;
    cpu_pkg::word_t     imm_sel;
    cpu_pkg::alu_op_t   op_d;
    logic               use_imm;
    logic               we_d;
    cpu_pkg::reg_addr_t waddr_d;
    cpu_pkg::id_ex_t    id_ex_d;

    assign opcode   = if_inst_i[31:26];
    assign rs       = if_inst_i[25:21];
    assign rt       = if_inst_i[20:16];
    assign rd       = if_inst_i[15:11];
    assign shamt    = if_inst_i[10:6];
    assign funct    = if_inst_i[5:0];
    assign imm      = if_inst_i[15:0];
    assign is_itype = (opcode != `OP_SPECIAL);

    assign imm_zext = {16'h0000, imm};
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_lui  = {imm, 16'h0000};

    // opcode/funct to alu op, anything else is a nop
    always_comb begin
        op_d = cpu_pkg::ALU_NOP;
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_AND:  op_d = cpu_pkg::ALU_AND;
                    `FN_OR:   op_d = cpu_pkg::ALU_OR;
                    `FN_XOR:  op_d = cpu_pkg::ALU_XOR;
                    `FN_NOR:  op_d = cpu_pkg::ALU_NOR;
                    `FN_ADDU: op_d = cpu_pkg::ALU_ADD;
                    `FN_SUBU: op_d = cpu_pkg::ALU_SUB;
                    `FN_SLL:  op_d = cpu_pkg::ALU_SLL;
                    `FN_SRL:  op_d = cpu_pkg::ALU_SRL;
                    `FN_MFHI: op_d = cpu_pkg::ALU_MFHI;
                    `FN_MFLO: op_d = cpu_pkg::ALU_MFLO;
                    `FN_MTHI: op_d = cpu_pkg::ALU_MTHI;
                    `FN_MTLO: op_d = cpu_pkg::ALU_MTLO;
                    default:  op_d = cpu_pkg::ALU_NOP;
                endcase
            end
            `OP_ANDI:  op_d = cpu_pkg::ALU_AND;
            `OP_ORI:   op_d = cpu_pkg::ALU_OR;
            `OP_XORI:  op_d = cpu_pkg::ALU_XOR;
            `OP_ADDIU: op_d = cpu_pkg::ALU_ADD;
            `OP_LUI:   op_d = cpu_pkg::ALU_LUI;
            default:   op_d = cpu_pkg::ALU_NOP;
        endcase
    end

    // read ports, immediate use and gpr write per op
    always_comb begin
        re1_o   = 1'b0;
        re2_o   = 1'b0;
        use_imm = 1'b0;
        we_d    = 1'b0;
        case (op_d)
            cpu_pkg::ALU_AND, cpu_pkg::ALU_OR, cpu_pkg::ALU_XOR,
            cpu_pkg::ALU_NOR, cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: begin
                re1_o   = 1'b1;
                re2_o   = !is_itype;  // i-type takes rt as destination
                use_imm = is_itype;
                we_d    = 1'b1;
            end
            cpu_pkg::ALU_SLL, cpu_pkg::ALU_SRL: begin
                re2_o = 1'b1;
                we_d  = 1'b1;
            end
            cpu_pkg::ALU_LUI: begin
                use_imm = 1'b1;
                we_d    = 1'b1;
            end
            cpu_pkg::ALU_MFHI, cpu_pkg::ALU_MFLO: we_d = 1'b1;
            cpu_pkg::ALU_MTHI, cpu_pkg::ALU_MTLO: re1_o = 1'b1;  // hi/lo only
            default: ;
        endcase
    end

    assign raddr1_o = rs;
    assign raddr2_o = rt;
    assign waddr_d  = is_itype ? rt : rd;

    always_comb begin
        if (op_d == cpu_pkg::ALU_ADD) begin
            imm_sel = imm_sext;
        end else if (op_d == cpu_pkg::ALU_LUI) begin
            imm_sel = imm_lui;
        end else begin
            imm_sel = imm_zext;
        end
    end

    always_comb begin
        id_ex_d.op    = op_d;
        id_ex_d.opnd1 = rdata1_i;  // zero when port 1 is off
        id_ex_d.opnd2 = use_imm ? imm_sel : rdata2_i;
        id_ex_d.shamt = shamt;
        id_ex_d.we    = we_d && (waddr_d != '0);  // $0 writes never leave decode
        id_ex_d.waddr = waddr_d;
    end

    // id/ex register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== decode/regfile.sv ====
// 32x32 register file, two read ports with ex/mem/wb forwarding
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     re1_i,
    input  wire cpu_pkg::reg_addr_t raddr1_i,
    input  wire                     re2_i,
    input  wire cpu_pkg::reg_addr_t raddr2_i,
    input  wire cpu_pkg::reg_wr_t   ex_fwd_i,
    input  wire cpu_pkg::reg_wr_t   mem_fwd_i,
    input  wire cpu_pkg::reg_wr_t   wb_i,
    output cpu_pkg::word_t          rdata1_o,
    output cpu_pkg::word_t          rdata2_o
);

    cpu_pkg::word_t regs [32];

    // newest value first: execute, memory, writeback, array
    function automatic cpu_pkg::word_t read_port(
        input logic               re,
        input cpu_pkg::reg_addr_t raddr,
        input cpu_pkg::reg_wr_t   ex_fwd,
        input cpu_pkg::reg_wr_t   mem_fwd,
        input cpu_pkg::reg_wr_t   wb,
        input cpu_pkg::word_t     stored
    );
        if (!re || raddr == '0) begin
            return '0;
        end else if (ex_fwd.we && ex_fwd.waddr == raddr) begin
            return ex_fwd.wdata;
        end else if (mem_fwd.we && mem_fwd.waddr == raddr) begin
            return mem_fwd.wdata;
        end else if (wb.we && wb.waddr == raddr) begin
            return wb.wdata;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    always_comb begin
        rdata1_o = read_port(re1_i, raddr1_i, ex_fwd_i, mem_fwd_i, wb_i, regs[raddr1_i]);
        rdata2_o = read_port(re2_i, raddr2_i, ex_fwd_i, mem_fwd_i, wb_i, regs[raddr2_i]);
    end

endmodule

`default_nettype wire

// ==== execute/exec_stage.sv ====
// alu, hi/lo moves and ex/mem register
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire cpu_pkg::id_ex_t  id_ex_i,
    input  wire cpu_pkg::hilo_wr_t hilo_i,
    output cpu_pkg::reg_wr_t      ex_fwd_o,
    output cpu_pkg::ex_mem_t      ex_mem_o
);

    cpu_pkg::word_t   alu_res;
    cpu_pkg::ex_mem_t ex_mem_d;

    always_comb begin
        case (id_ex_i.op)
            cpu_pkg::ALU_AND:  alu_res = id_ex_i.opnd1 & id_ex_i.opnd2;
            cpu_pkg::ALU_OR:   alu_res = id_ex_i.opnd1 | id_ex_i.opnd2;
            cpu_pkg::ALU_XOR:  alu_res = id_ex_i.opnd1 ^ id_ex_i.opnd2;
            cpu_pkg::ALU_NOR:  alu_res = ~(id_ex_i.opnd1 | id_ex_i.opnd2);
            cpu_pkg::ALU_ADD:  alu_res = id_ex_i.opnd1 + id_ex_i.opnd2;  // wraps, no overflow trap
            cpu_pkg::ALU_SUB:  alu_res = id_ex_i.opnd1 - id_ex_i.opnd2;
            cpu_pkg::ALU_SLL:  alu_res = id_ex_i.opnd2 << id_ex_i.shamt;
            cpu_pkg::ALU_SRL:  alu_res = id_ex_i.opnd2 >> id_ex_i.shamt;
            cpu_pkg::ALU_LUI:  alu_res = id_ex_i.opnd2;  // already shifted in decode
            cpu_pkg::ALU_MFHI: alu_res = hilo_i.hi;
            cpu_pkg::ALU_MFLO: alu_res = hilo_i.lo;
            default:           alu_res = '0;
        endcase
    end

    // combinational forward back to decode
    always_comb begin
        ex_fwd_o.we    = id_ex_i.we;
        ex_fwd_o.waddr = id_ex_i.waddr;
        ex_fwd_o.wdata = alu_res;
    end

    // mthi/mtlo move rs into the selected half
    always_comb begin
        ex_mem_d.rd    = ex_fwd_o;
        ex_mem_d.hl.hi_we = (id_ex_i.op == cpu_pkg::ALU_MTHI);
        ex_mem_d.hl.lo_we = (id_ex_i.op == cpu_pkg::ALU_MTLO);
        ex_mem_d.hl.hi    = id_ex_i.opnd1;
        ex_mem_d.hl.lo    = id_ex_i.opnd1;
    end

    // ex/mem register, its output is the memory stage
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
// mem/wb register, hi and lo registers and hi/lo forwarding
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire cpu_pkg::ex_mem_t ex_mem_i,
    output cpu_pkg::reg_wr_t      wb_o,
    output cpu_pkg::hilo_wr_t     hilo_o
);

    cpu_pkg::ex_mem_t mem_wb_q;
    cpu_pkg::word_t   hi_q;
    cpu_pkg::word_t   lo_q;

    // mem/wb register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= ex_mem_i;
        end
    end

    assign wb_o = mem_wb_q.rd;

    // hi and lo update at the end of writeback
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (mem_wb_q.hl.hi_we) begin
                hi_q <= mem_wb_q.hl.hi;
            end
            if (mem_wb_q.hl.lo_we) begin
                lo_q <= mem_wb_q.hl.lo;
            end
        end
    end

    // memory stage wins over writeback, each half on its own
    always_comb begin
        if (ex_mem_i.hl.hi_we) begin
            hilo_o.hi = ex_mem_i.hl.hi;
        end else if (mem_wb_q.hl.hi_we) begin
            hilo_o.hi = mem_wb_q.hl.hi;
        end else begin
            hilo_o.hi = hi_q;
        end
        if (ex_mem_i.hl.lo_we) begin
            hilo_o.lo = ex_mem_i.hl.lo;
        end else if (mem_wb_q.hl.lo_we) begin
            hilo_o.lo = mem_wb_q.hl.lo;
        end else begin
            hilo_o.lo = lo_q;
        end
        hilo_o.hi_we = ex_mem_i.hl.hi_we | mem_wb_q.hl.hi_we;  // value still in flight
        hilo_o.lo_we = ex_mem_i.hl.lo_we | mem_wb_q.hl.lo_we;
    end

endmodule

`default_nettype wire

// ==== src/openmips_core.sv ====
// core top level, stage wiring, rom port and writeback port
`timescale 1ns/1ps
`default_nettype none

module openmips_core (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire cpu_pkg::inst_t rom_data_i,
    output logic                rom_ce_o,
    output cpu_pkg::addr_t      rom_addr_o,
    output cpu_pkg::reg_wr_t    wb_o
);

    cpu_pkg::inst_t     if_inst;
    logic               re1;
    cpu_pkg::reg_addr_t raddr1;
    logic               re2;
    cpu_pkg::reg_addr_t raddr2;
    cpu_pkg::word_t     rdata1;
    cpu_pkg::word_t     rdata2;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::reg_wr_t   ex_fwd;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::hilo_wr_t  hilo;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst_i      (rst_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .if_pc_o    (),            // no consumer without branches
        .if_inst_o  (if_inst)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .if_inst_i (if_inst),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .re1_o     (re1),
        .raddr1_o  (raddr1),
        .re2_o     (re2),
        .raddr2_o  (raddr2),
        .id_ex_o   (id_ex)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_i     (rst_i),
        .re1_i     (re1),
        .raddr1_i  (raddr1),
        .re2_i     (re2),
        .raddr2_i  (raddr2),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (ex_mem.rd),    // memory stage forward
        .wb_i      (wb_o),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    exec_stage u_exec (
        .clk      (clk),
        .rst_i    (rst_i),
        .id_ex_i  (id_ex),
        .hilo_i   (hilo),
        .ex_fwd_o (ex_fwd),
        .ex_mem_o (ex_mem)
    );

    writeback_stage u_writeback (
        .clk      (clk),
        .rst_i    (rst_i),
        .ex_mem_i (ex_mem),
        .wb_o     (wb_o),
        .hilo_o   (hilo)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// testbench clock generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // first rising edge at half a period
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
// testbench top with rom model, program/expectation table, check task and result line
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module tb_top;

    localparam int ROM_WORDS  = 64;
    localparam int WB_TIMEOUT = 50;

    logic             clk;
    logic             rst_i;
    cpu_pkg::inst_t   rom_data_i;
    logic             rom_ce_o;
    cpu_pkg::addr_t   rom_addr_o;
    cpu_pkg::reg_wr_t wb_o;

    cpu_pkg::inst_t   prog [ROM_WORDS];
    int               prog_len;
    logic [4:0]       exp_reg [$];  // expected retirements, in order
    cpu_pkg::word_t   exp_val [$];
    int               errors;
    int               checks;
    int               cycle_cnt;
    int               word0_cycle;
    cpu_pkg::addr_t   exp_addr;
    logic             fetching;
    logic             timed_out;

    tb_clock #(.PERIOD_NS(20.0)) clk_gen (
        .clk_o (clk)
    );

    openmips_core dut0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .wb_o       (wb_o)
    );

    function automatic cpu_pkg::inst_t r_type(input int rs, input int rt, input int rd,
                                              input int sa, input logic [5:0] fn);
        return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
    endfunction

    function automatic cpu_pkg::inst_t i_type(input logic [5:0] op, input int rs, input int rt,
                                              input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // word index is the byte address over 4
    function automatic cpu_pkg::inst_t rom_word(input logic ce, input cpu_pkg::addr_t addr);
        cpu_pkg::addr_t idx;
        idx = addr >> 2;
        if (!ce || idx >= ROM_WORDS) begin
            return '0;
        end
        return prog[idx];
    endfunction

    // rom answers a little after the edge that moved the address
    always begin
        @(posedge clk);
        #2;
        rom_data_i = rom_word(rom_ce_o, rom_addr_o);
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic add_row(input cpu_pkg::inst_t inst, input logic wr, input int rd,
                           input cpu_pkg::word_t val);
        prog[prog_len] = inst;
        prog_len++;
        if (wr) begin
            exp_reg.push_back(rd[4:0]);
            exp_val.push_back(val);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            prog[i] = '0;
        end
        prog_len = 0;
        add_row(i_type(`OP_ORI, 0, 1, 16'h1234), 1, 1, 32'h0000_1234);
        add_row(i_type(`OP_ORI, 0, 2, 16'hff00), 1, 2, 32'h0000_ff00);
        add_row(i_type(`OP_ANDI, 1, 3, 16'h0ff0), 1, 3, 32'h0000_0230);  // $1 at distance 2
        add_row(i_type(`OP_XORI, 2, 4, 16'h8f0f), 1, 4, 32'h0000_700f);  // zero-extended
        add_row(i_type(`OP_LUI, 0, 5, 16'h8765), 1, 5, 32'h8765_0000);
        add_row(i_type(`OP_ADDIU, 5, 6, 16'hfff0), 1, 6, 32'h8764_fff0);  // -16
        add_row(i_type(`OP_ADDIU, 0, 7, 16'h8000), 1, 7, 32'hffff_8000);
        add_row(r_type(1, 2, 8, 0, `FN_AND), 1, 8, 32'h0000_1200);
        add_row(r_type(1, 2, 9, 0, `FN_OR), 1, 9, 32'h0000_ff34);
        add_row(r_type(1, 2, 10, 0, `FN_XOR), 1, 10, 32'h0000_ed34);
        add_row(r_type(1, 2, 11, 0, `FN_NOR), 1, 11, 32'hffff_00cb);
        add_row(r_type(5, 7, 12, 0, `FN_ADDU), 1, 12, 32'h8764_8000);  // carry out dropped
        add_row(r_type(1, 2, 13, 0, `FN_SUBU), 1, 13, 32'hffff_1334);
        add_row(r_type(0, 1, 14, 4, `FN_SLL), 1, 14, 32'h0001_2340);
        add_row(r_type(0, 5, 15, 8, `FN_SRL), 1, 15, 32'h0087_6500);
        // forwarding chain
        add_row(i_type(`OP_ADDIU, 0, 16, 16'h0005), 1, 16, 32'h0000_0005);
        add_row(i_type(`OP_ADDIU, 16, 16, 16'h0003), 1, 16, 32'h0000_0008);  // distance 1
        add_row(i_type(`OP_ORI, 16, 18, 16'h0100), 1, 18, 32'h0000_0108);  // newest $16 wins
        add_row(r_type(16, 16, 17, 0, `FN_ADDU), 1, 17, 32'h0000_0010);  // distance 2
        add_row(i_type(`OP_ORI, 0, 19, 16'h0200), 1, 19, 32'h0000_0200);
        add_row(i_type(`OP_ORI, 0, 20, 16'h0300), 1, 20, 32'h0000_0300);
        add_row(r_type(17, 18, 21, 0, `FN_SUBU), 1, 21, 32'hffff_ff08);  // distance 3
        add_row(i_type(`OP_ORI, 0, 0, 16'habcd), 0, 0, '0);  // write to $0 dropped
        add_row(r_type(0, 1, 22, 0, `FN_ADDU), 1, 22, 32'h0000_1234);
        // hi/lo moves back to back and after a gap
        add_row(r_type(2, 0, 30, 0, `FN_MTHI), 0, 0, '0);  // rd field ignored
        add_row(r_type(0, 0, 23, 0, `FN_MFHI), 1, 23, 32'h0000_ff00);
        add_row(r_type(1, 0, 30, 0, `FN_MTLO), 0, 0, '0);
        add_row(r_type(0, 0, 24, 0, `FN_MFLO), 1, 24, 32'h0000_1234);
        add_row('0, 0, 0, '0);
        add_row('0, 0, 0, '0);
        add_row(r_type(0, 0, 25, 0, `FN_MFHI), 1, 25, 32'h0000_ff00);
        add_row(r_type(0, 0, 26, 0, `FN_MFLO), 1, 26, 32'h0000_1234);
        add_row(r_type(6, 0, 30, 0, `FN_MTHI), 0, 0, '0);
        add_row(r_type(0, 0, 27, 0, `FN_MFLO), 1, 27, 32'h0000_1234);  // lo untouched
        add_row(r_type(0, 0, 28, 0, `FN_MFHI), 1, 28, 32'h8764_fff0);
        // unknown encodings retire nothing
        add_row(i_type(6'h3f, 1, 29, 16'h1111), 0, 0, '0);
        add_row(r_type(1, 2, 29, 0, 6'h3e), 0, 0, '0);
        add_row(i_type(`OP_ORI, 0, 29, 16'h00aa), 1, 29, 32'h0000_00aa);
    endtask

    // steps one cycle and tracks the fetch address at mid-cycle
    task automatic step_cycle();
        @(negedge clk);
        cycle_cnt++;
        if (rom_ce_o) begin
            fetching = 1'b1;
            if (word0_cycle < 0 && rom_addr_o == `CPU_RESET_PC) begin
                word0_cycle = cycle_cnt;
            end
            check_val("rom_addr_o", rom_addr_o, exp_addr);
            exp_addr = exp_addr + `CPU_PC_STEP;
        end else if (fetching) begin
            errors++;
            $display("rom_ce_o went low while the core was fetching at %0t", $time);
        end
    endtask

    task automatic wait_writeback(output logic ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < WB_TIMEOUT) begin
            step_cycle();
            ok = wb_o.we;
            n++;
        end
    endtask

    initial begin
        logic got;
        int   n;
        errors      = 0;
        checks      = 0;
        cycle_cnt   = 0;
        word0_cycle = -1;
        exp_addr    = `CPU_RESET_PC;
        fetching    = 1'b0;
        timed_out   = 1'b0;
        rst_i       = 1'b1;
        rom_data_i  = '0;
        load_program();

        repeat (8) begin
            @(posedge clk);
            #2;
            check_val("rom_ce_o", rom_ce_o, 1'b0);
            check_val("wb_o.we", wb_o.we, 1'b0);
        end
        rst_i = 1'b0;

        n = 0;
        while (!rom_ce_o && n < 10) begin
            step_cycle();
            n++;
        end
        if (!rom_ce_o) begin
            errors++;
            timed_out = 1'b1;
            $display("rom_ce_o never rose after reset");
        end

        for (int i = 0; i < exp_reg.size() && !timed_out; i++) begin
            wait_writeback(got);
            if (!got) begin
                errors++;
                timed_out = 1'b1;
                $display("no writeback %0d within %0d cycles", i, WB_TIMEOUT);
            end else begin
                if (i == 0) begin
                    check_val("wb latency", cycle_cnt - word0_cycle, 4);
                end
                check_val("wb_o.waddr", wb_o.waddr, exp_reg[i]);
                check_val("wb_o.wdata", wb_o.wdata, exp_val[i]);
            end
        end

        // trailing zero words must stay silent
        if (!timed_out) begin
            repeat (8) begin
                step_cycle();
                check_val("wb_o.we", wb_o.we, 1'b0);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/cpu_pkg.sv
src/fetch_stage.sv
decode/decode_stage.sv
decode/regfile.sv
execute/exec_stage.sv
src/writeback_stage.sv
src/openmips_core.sv
dv/tb_clock.sv
dv/tb_top.sv
